//--- pwm_unit.f
+incdir+include
src/pwm_pkg.sv
src/pwm_shadow_reg.sv
src/pwm_period_timer.sv
src/pwm_heartbeat_ramp.sv
src/pwm_ctrl.sv
src/pwm_unit.sv
dv/pwm_clk_gen.sv
dv/pwm_unit_checker.sv
dv/pwm_tb.sv

//--- Bender.yml
package:
  name: pwm_unit

export_include_dirs:
  - include

sources:
  - src/pwm_pkg.sv
  - src/pwm_shadow_reg.sv
  - src/pwm_period_timer.sv
  - src/pwm_heartbeat_ramp.sv
  - src/pwm_ctrl.sv
  - src/pwm_unit.sv
  - target: simulation
    files:
      - dv/pwm_clk_gen.sv
      - dv/pwm_unit_checker.sv
      - dv/pwm_tb.sv

//--- dv/pwm_tb.sv
// Table-driven PWM unit testbench with reference model, compare tasks and watchdog
`timescale 1ns/1ps
`include "pwm_settings.svh"

module pwm_tb
  import pwm_pkg::*;
();

  typedef logic [`PWM_RES-1:0] res_t;

  // Mode, period, prescale, threshold, bounds, increment, periods to observe,
  // then a flag and the threshold and bounds written during the first observed period
  typedef struct {
    pwm_mode_e mode;
    int        period;
    int        ps;
    int        th;
    int        a;
    int        b;
    int        inc;
    int        n;
    int        upd;
    int        nth;
    int        na;
    int        nb;
  } row_t;

  localparam int NUM_ROWS = 10;

  row_t rows[NUM_ROWS] = '{
    '{PWM_STD, 9, 0, 4, 0, 0, 0, 3, 0, 0, 0, 0},
    '{PWM_STD, 7, 2, 5, 0, 0, 0, 3, 0, 0, 0, 0},
    // Always low, then always high
    '{PWM_STD, 5, 1, 0, 0, 0, 0, 2, 0, 0, 0, 0},
    '{PWM_STD, 5, 3, 20, 0, 0, 0, 2, 0, 0, 0, 0},
    '{PWM_STD, 15, 1, 3, 0, 0, 0, 3, 1, 12, 0, 0},
    // Heartbeat with both bound orders
    '{PWM_HB, 15, 0, 0, 2, 12, 4, 8, 0, 0, 0, 0},
    '{PWM_HB, 15, 0, 0, 12, 2, 4, 8, 0, 0, 0, 0},
    '{PWM_HB, 15, 1, 0, 3, 13, 5, 6, 0, 0, 0, 0},
    // Bounds move mid-ramp
    '{PWM_HB, 31, 0, 0, 2, 12, 4, 7, 1, 0, 24, 6},
    // Prescale and threshold drawn at start
    '{PWM_STD, 15, 0, 0, 0, 0, 0, 3, 0, 0, 0, 0}
  };

  logic        clk_i;
  logic        rst_ni;
  pwm_wr_t     wr;
  logic        pwm_o;
  logic        period_o;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 32'hffff_ffff;

  pwm_clk_gen u_clk_gen (.clk_i(clk_i), .rst_ni(rst_ni));

  pwm_unit uut (.clk_i(clk_i), .rst_ni(rst_ni), .wr(wr), .pwm_o(pwm_o), .period_o(period_o));

  function automatic int expect_high(pwm_mode_e mode, int period, int ps, int th, int level);
    int thresh;
    thresh = (mode == PWM_HB) ? level : th;
    if (thresh > period + 1) begin
      thresh = period + 1;
    end
    return thresh * (ps + 1);
  endfunction

  // Smaller or larger of two bounds
  function automatic int bound(int a, int b, bit upper);
    return ((a > b) == upper) ? a : b;
  endfunction

  function automatic void step_ramp(inout int level, inout bit down, input int a, int b, int inc);
    int lo;
    int hi;
    lo = bound(a, b, 1'b0);
    hi = bound(a, b, 1'b1);
    if (!down && level + inc > hi) begin
      down  = 1'b1;
      level = level - inc;
    end else if (down && level < lo + inc) begin
      down  = 1'b0;
      level = level + inc;
    end else begin
      level = down ? level - inc : level + inc;
    end
  endfunction

  task automatic write_reg(input logic [`PWM_ADDR_W-1:0] addr, input res_t data);
    @(posedge clk_i);
    wr <= '{en: 1'b1, addr: addr, data: data};
    @(posedge clk_i);
    wr <= '0;
  endtask

  task automatic check_count(input res_t got, input res_t exp, input int t, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: test %0d %s is %0d, expected %0d", $time, t, what, got, exp);
    end
  endtask

  task automatic check_len(input res_t got, input res_t exp, input int t, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: test %0d %s is %0d, expected %0d", $time, t, what, got, exp);
    end
  endtask

  // Counts cycles up to and including the next period_o
  task automatic measure_period(output res_t high, output res_t len, output bit seen,
                                input int limit);
    high = '0;
    len  = '0;
    seen = 1'b0;
    while (!seen && int'(len) < limit) begin
      @(negedge clk_i);
      len++;
      if (pwm_o) high++;
      if (period_o) seen = 1'b1;
    end
  endtask

  task automatic check_off(input int t, input int n_cycles);
    res_t highs;
    res_t pulses;
    highs  = '0;
    pulses = '0;
    // First cycle still holds the last registered output
    @(negedge clk_i);
    repeat (n_cycles) begin
      @(negedge clk_i);
      if (pwm_o) highs++;
      if (period_o) pulses++;
    end
    check_count(highs, '0, t, "pwm_o high cycles while off");
    check_count(pulses, '0, t, "period_o pulses while off");
  endtask

  task automatic run_row(input int t, input row_t r);
    int   th;
    int   a;
    int   b;
    int   level;
    int   len;
    int   lim;
    int   errs_in;
    bit   down;
    bit   restart;
    bit   seen;
    res_t high_m;
    res_t len_m;
    th      = r.th;
    a       = r.a;
    b       = r.b;
    level   = bound(a, b, 1'b0);
    len     = (r.period + 1) * (r.ps + 1);
    lim     = len + 9;
    down    = 1'b0;
    restart = 1'b0;
    errs_in = errors;
    write_reg(`PWM_REG_MODE, res_t'(PWM_OFF));
    check_off(t, 8);
    write_reg(`PWM_REG_PERIOD, res_t'(r.period));
    write_reg(`PWM_REG_PRESCALE, res_t'(r.ps));
    write_reg(`PWM_REG_THRESH, res_t'(r.th));
    write_reg(`PWM_REG_BOUND_A, res_t'(r.a));
    write_reg(`PWM_REG_BOUND_B, res_t'(r.b));
    write_reg(`PWM_REG_INC, res_t'(r.inc));
    write_reg(`PWM_REG_MODE, res_t'(r.mode));
    // First window also holds the idle output cycle before the period
    measure_period(high_m, len_m, seen, lim);
    if (seen) begin
      check_len(len_m, res_t'(len + 1), t, "first period length");
      check_count(high_m, res_t'(expect_high(r.mode, r.period, r.ps, th, level)), t,
                  "first period high count");
      step_ramp(level, down, a, b, r.inc);
      lim = len + 8;
    end
    for (int i = 1; i <= r.n && seen; i++) begin
      if (r.upd != 0 && i == 1) begin
        fork
          measure_period(high_m, len_m, seen, lim);
          begin
            repeat (2) @(posedge clk_i);
            write_reg(`PWM_REG_THRESH, res_t'(r.nth));
            write_reg(`PWM_REG_BOUND_A, res_t'(r.na));
            write_reg(`PWM_REG_BOUND_B, res_t'(r.nb));
          end
        join
      end else begin
        measure_period(high_m, len_m, seen, lim);
      end
      if (seen) begin
        check_len(len_m, res_t'(len), t, $sformatf("period %0d length", i));
        check_count(high_m, res_t'(expect_high(r.mode, r.period, r.ps, th, level)), t,
                    $sformatf("period %0d high count", i));
        if (restart) begin
          level   = bound(a, b, 1'b0);
          down    = 1'b0;
          restart = 1'b0;
        end else begin
          step_ramp(level, down, a, b, r.inc);
        end
        // Staged values become active at the end of this period
        if (r.upd != 0 && i == 1) begin
          restart = (bound(r.na, r.nb, 1'b0) != bound(a, b, 1'b0)) ||
                    (bound(r.na, r.nb, 1'b1) != bound(a, b, 1'b1));
          th = r.nth;
          a  = r.na;
          b  = r.nb;
        end
      end
    end
    if (!seen) begin
      errors++;
      $display("test %0d: no period_o seen within %0d cycles", t, lim);
    end
    tests++;
    $display("test %0d %s: %0d periods %s", t, r.mode.name(), r.n,
             (errors == errs_in) ? "ok" : "FAILED");
  endtask

  // Watchdog on total run length
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run took more than %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    wr = '0;
    void'($urandom(32'h715e));
    rows[NUM_ROWS-1].ps = $urandom % 4;
    rows[NUM_ROWS-1].th = $urandom % 20;
    cycle_limit = 200;
    foreach (rows[i]) begin
      cycle_limit += 40 + (rows[i].n + 2) * (rows[i].period + 1) * (rows[i].ps + 1);
    end
    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    for (int t = 0; t < NUM_ROWS; t++) begin
      run_row(t, rows[t]);
    end
    errors += uut.u_checker.fail_count;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- dv/pwm_unit_checker.sv
// Concurrent assertions on the PWM top level outputs and their bind
`timescale 1ns/1ps

module pwm_unit_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic run,
  input logic pwm_o,
  input logic period_o
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Outputs cleared by reset
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |=> (!pwm_o && !period_o))
    else begin
      $error("pwm_o or period_o high after a reset cycle");
      fail_count++;
    end

  // Period pulse lasts one cycle
  single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    period_o |=> !period_o)
    else begin
      $error("period_o high for two cycles in a row");
      fail_count++;
    end

  // Output stage lags run by one cycle
  off_low: assert property (@(posedge clk_i) disable iff (!rst_ni) !run |=> !pwm_o)
    else begin
      $error("pwm_o high while the mode is off");
      fail_count++;
    end

endmodule

bind pwm_unit pwm_unit_checker u_checker (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .run      (run),
  .pwm_o    (pwm_o),
  .period_o (period_o)
);

//--- dv/pwm_clk_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module pwm_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 20,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #(HALF_PERIOD) clk_i = ~clk_i;
  end

  // Reset released on a rising edge
  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

endmodule

//--- src/pwm_unit.sv
// PWM generator top level with control, shadow registers, timer and ramp
`timescale 1ns/1ps
`include "pwm_settings.svh"

module pwm_unit
  import pwm_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  pwm_wr_t wr,
  output logic    pwm_o,
  output logic    period_o
);

  pwm_std_cfg_t        std_stage;
  pwm_std_cfg_t        std_active;
  pwm_hb_cfg_t         hb_stage;
  pwm_hb_cfg_t         hb_active;
  logic                load;
  logic                run;
  logic                ramp_step;
  logic                period_end;
  logic [`PWM_RES-1:0] count;
  logic [`PWM_RES-1:0] level;

  pwm_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr         (wr),
    .count      (count),
    .period_end (period_end),
    .std_active (std_active),
    .level      (level),
    .std_stage  (std_stage),
    .hb_stage   (hb_stage),
    .load       (load),
    .run        (run),
    .ramp_step  (ramp_step),
    .pwm_o      (pwm_o),
    .period_o   (period_o)
  );

  pwm_shadow_reg #(.T(pwm_std_cfg_t)) u_std_shadow (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load   (load),
    .d      (std_stage),
    .q      (std_active)
  );

  pwm_shadow_reg #(.T(pwm_hb_cfg_t)) u_hb_shadow (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load   (load),
    .d      (hb_stage),
    .q      (hb_active)
  );

  pwm_period_timer u_timer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .run        (run),
    .cfg        (std_active),
    .count      (count),
    .period_end (period_end)
  );

  pwm_heartbeat_ramp u_ramp (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .run       (run),
    .cfg       (hb_active),
    .ramp_step (ramp_step),
    .level     (level)
  );

endmodule

//--- src/pwm_ctrl.sv
// PWM register decode, mode control, shadow-load timing and output stage
`timescale 1ns/1ps
`include "pwm_settings.svh"

module pwm_ctrl
  import pwm_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  pwm_wr_t             wr,
  input  logic [`PWM_RES-1:0] count,
  input  logic                period_end,
  input  pwm_std_cfg_t        std_active,
  input  logic [`PWM_RES-1:0] level,
  output pwm_std_cfg_t        std_stage,
  output pwm_hb_cfg_t         hb_stage,
  output logic                load,
  output logic                run,
  output logic                ramp_step,
  output logic                pwm_o,
  output logic                period_o
);

  pwm_mode_e           mode_q;
  logic [`PWM_RES-1:0] thresh;

  // Register writes land in the staging structs
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mode_q    <= PWM_OFF;
      std_stage <= '0;
      hb_stage  <= '0;
    end else if (wr.en) begin
      case (wr.addr)
        `PWM_REG_MODE: begin
          // Encoding 3 is not a mode
          if (wr.data[1:0] != 2'd3) begin
            mode_q <= pwm_mode_e'(wr.data[1:0]);
          end
        end
        `PWM_REG_PERIOD:   std_stage.period    <= wr.data;
        `PWM_REG_PRESCALE: std_stage.prescale  <= wr.data;
        `PWM_REG_THRESH:   std_stage.threshold <= wr.data;
        `PWM_REG_BOUND_A:  hb_stage.bound_a    <= wr.data;
        `PWM_REG_BOUND_B:  hb_stage.bound_b    <= wr.data;
        `PWM_REG_INC:      hb_stage.increment  <= wr.data;
        default: ;
      endcase
    end
  end

  assign run       = (mode_q != PWM_OFF);
  // Shadows follow staging freely while stopped
  assign load      = period_end || (mode_q == PWM_OFF);
  assign ramp_step = period_end && (mode_q == PWM_HB);

  // Active duty threshold
  assign thresh = (mode_q == PWM_HB) ? level : std_active.threshold;

  // Output stage, one cycle behind count
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pwm_o    <= 1'b0;
      period_o <= 1'b0;
    end else begin
      pwm_o    <= run && (count < thresh);
      period_o <= period_end;
    end
  end

endmodule

//--- src/pwm_heartbeat_ramp.sv
// Heartbeat duty-level generator bouncing between two sorted bounds
`timescale 1ns/1ps
`include "pwm_settings.svh"

module pwm_heartbeat_ramp
  import pwm_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                run,
  input  pwm_hb_cfg_t         cfg,
  input  logic                ramp_step,
  output logic [`PWM_RES-1:0] level
);

  logic [`PWM_RES-1:0] lo;
  logic [`PWM_RES-1:0] hi;
  logic [`PWM_RES-1:0] lo_q;
  logic [`PWM_RES-1:0] hi_q;
  logic [`PWM_RES-1:0] level_q;
  logic [`PWM_RES:0]   level_up;
  logic [`PWM_RES:0]   lo_plus_inc;
  logic                dir_down_q;
  logic                run_q;
  logic                restart_q;
  logic                bounds_changed;

  // Sort the bounds
  assign lo = (cfg.bound_a <= cfg.bound_b) ? cfg.bound_a : cfg.bound_b;
  assign hi = (cfg.bound_a >  cfg.bound_b) ? cfg.bound_a : cfg.bound_b;

  // One extra bit so the turn test cannot wrap
  assign level_up    = {1'b0, level_q} + {1'b0, cfg.increment};
  assign lo_plus_inc = {1'b0, lo} + {1'b0, cfg.increment};

  assign bounds_changed = (lo != lo_q) || (hi != hi_q);

  // Registered bounds, compared against the live ones
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lo_q  <= '0;
      hi_q  <= '0;
      run_q <= 1'b0;
    end else begin
      lo_q  <= lo;
      hi_q  <= hi;
      run_q <= run;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      level_q    <= '0;
      dir_down_q <= 1'b0;
      restart_q  <= 1'b0;
    end else if (!run || !run_q) begin
      // Idle or first running cycle, start at lo going up
      level_q    <= lo;
      dir_down_q <= 1'b0;
      restart_q  <= 1'b0;
    end else if (ramp_step) begin
      restart_q <= 1'b0;
      if (restart_q) begin
        level_q    <= lo;
        dir_down_q <= 1'b0;
      end else if (!dir_down_q && (level_up > {1'b0, hi})) begin
        // Turn at the upper bound
        level_q    <= level_q - cfg.increment;
        dir_down_q <= 1'b1;
      end else if (dir_down_q && ({1'b0, level_q} < lo_plus_inc)) begin
        // Turn at the lower bound
        level_q    <= level_q + cfg.increment;
        dir_down_q <= 1'b0;
      end else if (dir_down_q) begin
        level_q <= level_q - cfg.increment;
      end else begin
        level_q <= level_up[`PWM_RES-1:0];
      end
    end else if (bounds_changed) begin
      // New bounds arrive mid-ramp, restart on the next step
      restart_q <= 1'b1;
    end
  end

  assign level = level_q;

endmodule

//--- src/pwm_period_timer.sv
// Prescaled PWM period counter with period-end pulse
`timescale 1ns/1ps
`include "pwm_settings.svh"

module pwm_period_timer
  import pwm_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                run,
  input  pwm_std_cfg_t        cfg,
  output logic [`PWM_RES-1:0] count,
  output logic                period_end
);

  logic [`PWM_RES-1:0] presc_q;
  logic [`PWM_RES-1:0] count_q;
  logic                presc_wrap;
  logic                count_wrap;

  // Each count value lasts prescale+1 cycles
  assign presc_wrap = (presc_q == cfg.prescale);
  assign count_wrap = (count_q == cfg.period);

  // Last cycle of the last count value
  assign period_end = run && presc_wrap && count_wrap;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      presc_q <= '0;
      count_q <= '0;
    end else if (!run) begin
      // Idle, next period starts from zero
      presc_q <= '0;
      count_q <= '0;
    end else if (presc_wrap) begin
      presc_q <= '0;
      if (count_wrap) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  assign count = count_q;

endmodule

//--- src/pwm_shadow_reg.sv
// Type-parameterized shadow register loaded by a strobe
`timescale 1ns/1ps

module pwm_shadow_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic load,
  input  T     d,
  output T     q
);

  // Active copy seen by the datapath
  T q_r;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      q_r <= '0;
    end else if (load) begin
      // Whole payload moves in one edge
      q_r <= d;
    end
  end

  assign q = q_r;

endmodule

//--- src/pwm_pkg.sv
// PWM mode enum, configuration structs and register write bus type
`include "pwm_settings.svh"

package pwm_pkg;

  // Operating mode, written through the mode register
  typedef enum logic [1:0] {
    PWM_OFF = 2'd0,
    PWM_STD = 2'd1,
    PWM_HB  = 2'd2
  } pwm_mode_e;

  // Standard mode configuration, also drives the period timer
  typedef struct packed {
    logic [`PWM_RES-1:0] period;
    logic [`PWM_RES-1:0] prescale;
    logic [`PWM_RES-1:0] threshold;
  } pwm_std_cfg_t;

  // Heartbeat ramp configuration
  // Bounds may come in either order
  typedef struct packed {
    logic [`PWM_RES-1:0] bound_a;
    logic [`PWM_RES-1:0] bound_b;
    logic [`PWM_RES-1:0] increment;
  } pwm_hb_cfg_t;

  // Single-cycle register write strobe
  typedef struct packed {
    logic                  en;
    logic [`PWM_ADDR_W-1:0] addr;
    logic [`PWM_RES-1:0]    data;
  } pwm_wr_t;

endpackage

//--- include/pwm_settings.svh
// PWM counter resolution, register address width and register map
`ifndef PWM_SETTINGS_SVH
`define PWM_SETTINGS_SVH

// Width of counters, thresholds and register data
`define PWM_RES 16

// Register address width
`define PWM_ADDR_W 3

// Register map
`define PWM_REG_MODE     3'd0
`define PWM_REG_PERIOD   3'd1
`define PWM_REG_PRESCALE 3'd2
`define PWM_REG_THRESH   3'd3
`define PWM_REG_BOUND_A  3'd4
`define PWM_REG_BOUND_B  3'd5
`define PWM_REG_INC      3'd6

`endif
